//--- verilog/err_cnt_pkg.sv
package err_cnt_pkg;

    ////////////////////////////////////////////////////////////
    // Frame geometry
    ////////////////////////////////////////////////////////////

    // Row chunks per decoded frame
    localparam int ROW_CHUNK_NUM = 9;
    localparam int CHUNK_BITS    = 850;
    localparam int FRAME_BITS    = ROW_CHUNK_NUM * CHUNK_BITS;

    // Six full sub-frames plus one short one per chunk
    localparam int SUB_NUM       = 7;
    localparam int SUB_BITS      = 128;
    localparam int LAST_SUB_BITS = CHUNK_BITS - (SUB_NUM - 1) * SUB_BITS;

    ////////////////////////////////////////////////////////////
    // Count widths
    ////////////////////////////////////////////////////////////

    localparam int SUB_CNT_W   = 8;
    localparam int CHUNK_CNT_W = 10;
    localparam int ERR_CNT_W   = 13;

    ////////////////////////////////////////////////////////////
    // Latencies
    ////////////////////////////////////////////////////////////

    // Capture to accumulate, in eval_clk cycles
    localparam int PIPE_DEPTH   = 5;
    // count_done width, decoder runs at half rate
    localparam int DONE_STRETCH = 2;

    // Controller states
    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        DRAIN,
        DONE
    } ctrl_state_t;

endpackage

//--- verilog/subframe_popcount.sv
`timescale 1ns/100ps

module subframe_popcount
    import err_cnt_pkg::*;
#(
    parameter int WIDTH = SUB_BITS
) (
    input  logic                 eval_clk,
    input  logic                 rstn,
    input  logic                 en,
    input  logic [WIDTH-1:0]     slice,
    output logic [SUB_CNT_W-1:0] sub_count
);

    logic [WIDTH-1:0]     slice_q;
    logic [SUB_CNT_W-1:0] ones;

    ////////////////////////////////////////////////////////////
    // Stage 0, hold the slice of the current chunk
    ////////////////////////////////////////////////////////////

    always_ff @(posedge eval_clk or negedge rstn) begin
        if (!rstn) begin
            slice_q <= '0;
        end else if (en) begin
            slice_q <= slice;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage 1, count the ones
    ////////////////////////////////////////////////////////////

    // Plain adder chain, synthesis builds the tree
    always_comb begin
        ones = '0;
        for (int b = 0; b < WIDTH; b++) begin
            ones = ones + SUB_CNT_W'(slice_q[b]);
        end
    end

    // Register runs every cycle, the tag line tracks validity
    always_ff @(posedge eval_clk or negedge rstn) begin
        if (!rstn) begin
            sub_count <= '0;
        end else begin
            sub_count <= ones;
        end
    end

endmodule

//--- verilog/count_sum_tree.sv
`timescale 1ns/100ps

module count_sum_tree
    import err_cnt_pkg::*;
(
    input  logic                           eval_clk,
    input  logic                           rstn,
    input  logic [SUB_NUM*SUB_CNT_W-1:0]   sub_counts,
    output logic [CHUNK_CNT_W-1:0]         ones_sum
);

    // Four partial sums after the first level
    localparam int PART_NUM = (SUB_NUM + 1) / 2;
    localparam int PART_W   = SUB_CNT_W + 1;

    logic [PART_NUM-1:0][PART_W-1:0] part_q;
    logic [CHUNK_CNT_W-1:0]          total;

    ////////////////////////////////////////////////////////////
    // Level 1, pairwise sums
    ////////////////////////////////////////////////////////////

    always_ff @(posedge eval_clk or negedge rstn) begin
        if (!rstn) begin
            part_q <= '0;
        end else begin
            for (int p = 0; p < PART_NUM; p++) begin
                if (2 * p + 1 < SUB_NUM) begin
                    part_q[p] <= PART_W'(sub_counts[2*p*SUB_CNT_W +: SUB_CNT_W])
                               + PART_W'(sub_counts[(2*p+1)*SUB_CNT_W +: SUB_CNT_W]);
                end else begin
                    // Odd one out goes straight through
                    part_q[p] <= PART_W'(sub_counts[2*p*SUB_CNT_W +: SUB_CNT_W]);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Level 2, final sum
    ////////////////////////////////////////////////////////////

    always_comb begin
        total = '0;
        for (int p = 0; p < PART_NUM; p++) begin
            total = total + CHUNK_CNT_W'(part_q[p]);
        end
    end

    always_ff @(posedge eval_clk or negedge rstn) begin
        if (!rstn) begin
            ones_sum <= '0;
        end else begin
            ones_sum <= total;
        end
    end

    // A chunk cannot hold more ones than it has bits
    a_sum_range: assert property (@(posedge eval_clk) disable iff (!rstn)
        ones_sum <= CHUNK_BITS);

endmodule

//--- verilog/err_accumulator.sv
`timescale 1ns/100ps

module err_accumulator
    import err_cnt_pkg::*;
(
    input  logic                   eval_clk,
    input  logic                   rstn,
    input  logic [CHUNK_CNT_W-1:0] ones_sum,
    input  logic                   acc_valid,
    input  logic                   acc_first,
    output logic [ERR_CNT_W-1:0]   err_count,
    output logic                   is_err_frame
);

    logic [CHUNK_CNT_W-1:0] chunk_err;
    logic                   chunk_has_err;

    ////////////////////////////////////////////////////////////
    // Normalise
    ////////////////////////////////////////////////////////////

    // All-zero codeword under BPSK, so every 0 is a bit error
    always_ff @(posedge eval_clk or negedge rstn) begin
        if (!rstn) begin
            chunk_err <= '0;
        end else begin
            chunk_err <= CHUNK_CNT_W'(CHUNK_BITS) - ones_sum;
        end
    end

    assign chunk_has_err = |chunk_err;

    ////////////////////////////////////////////////////////////
    // Accumulate over the frame
    ////////////////////////////////////////////////////////////

    always_ff @(posedge eval_clk or negedge rstn) begin
        if (!rstn) begin
            err_count    <= '0;
            is_err_frame <= 1'b0;
        end else if (acc_valid) begin
            if (acc_first) begin
                // First chunk restarts the frame total
                err_count    <= ERR_CNT_W'(chunk_err);
                is_err_frame <= chunk_has_err;
            end else begin
                err_count    <= err_count + ERR_CNT_W'(chunk_err);
                is_err_frame <= is_err_frame | chunk_has_err;
            end
        end
    end

    // Tags from the controller must keep the total inside one frame
    a_total_range: assert property (@(posedge eval_clk) disable iff (!rstn)
        err_count <= FRAME_BITS);

endmodule

//--- verilog/err_cnt_ctrl.sv
`timescale 1ns/100ps

module err_cnt_ctrl
    import err_cnt_pkg::*;
(
    input  logic eval_clk,
    input  logic rstn,
    input  logic en,
    output logic acc_valid,
    output logic acc_first,
    output logic busy,
    output logic count_done
);

    ctrl_state_t state;

    logic [$clog2(ROW_CHUNK_NUM)-1:0] chunk_cnt;
    logic [$clog2(DONE_STRETCH)-1:0]  done_cnt;
    logic [PIPE_DEPTH-1:0]            valid_tag;
    logic [PIPE_DEPTH-1:0]            first_tag;
    logic                             take;
    logic                             take_first;

    // Chunks are only taken while a frame is being loaded
    assign take       = en && (state == IDLE || state == LOAD);
    assign take_first = en && (state == IDLE);

    ////////////////////////////////////////////////////////////
    // Tag line, one slot per pipeline stage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge eval_clk or negedge rstn) begin
        if (!rstn) begin
            valid_tag <= '0;
            first_tag <= '0;
        end else begin
            valid_tag <= {valid_tag[PIPE_DEPTH-2:0], take};
            first_tag <= {first_tag[PIPE_DEPTH-2:0], take_first};
        end
    end

    assign acc_valid = valid_tag[PIPE_DEPTH-1];
    assign acc_first = first_tag[PIPE_DEPTH-1];

    ////////////////////////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge eval_clk or negedge rstn) begin
        if (!rstn) begin
            state     <= IDLE;
            chunk_cnt <= '0;
            done_cnt  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (en) begin
                        state     <= LOAD;
                        chunk_cnt <= 1;
                    end
                end
                LOAD: begin
                    chunk_cnt <= chunk_cnt + 1'b1;
                    if (chunk_cnt == ROW_CHUNK_NUM - 1) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    // Last chunk leaves the tag line on this edge
                    if (acc_valid && !(|valid_tag[PIPE_DEPTH-2:0])) begin
                        state    <= DONE;
                        done_cnt <= '0;
                    end
                end
                DONE: begin
                    done_cnt <= done_cnt + 1'b1;
                    if (done_cnt == DONE_STRETCH - 1) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Outputs lag the state by one edge
    always_ff @(posedge eval_clk or negedge rstn) begin
        if (!rstn) begin
            busy       <= 1'b0;
            count_done <= 1'b0;
        end else begin
            busy       <= (state == LOAD) || (state == DRAIN);
            count_done <= (state == DONE);
        end
    end

    // No new frame while the previous one drains or reports
    a_no_overlap: assert property (@(posedge eval_clk) disable iff (!rstn)
        (state == DRAIN || state == DONE) |-> !en);

    // en stays high for the full nine chunks
    a_full_frame: assert property (@(posedge eval_clk) disable iff (!rstn)
        (state == LOAD) |-> en);

endmodule

//--- verilog/err_bit_cnt_top.sv
`timescale 1ns/100ps

module err_bit_cnt_top
    import err_cnt_pkg::*;
(
    input  logic                  eval_clk,
    input  logic                  rstn,
    input  logic                  en,
    input  logic [CHUNK_BITS-1:0] hard_frame,
    output logic [ERR_CNT_W-1:0]  err_count,
    output logic                  is_err_frame,
    output logic                  busy,
    output logic                  count_done
);

    logic [SUB_NUM*SUB_CNT_W-1:0] sub_counts;
    logic [CHUNK_CNT_W-1:0]       ones_sum;
    logic                         acc_valid;
    logic                         acc_first;

    ////////////////////////////////////////////////////////////
    // Sub-frame popcounts
    ////////////////////////////////////////////////////////////

    for (genvar j = 0; j < SUB_NUM; j++) begin : g_sub
        if (j < SUB_NUM - 1) begin : g_full
            subframe_popcount #(
                .WIDTH (SUB_BITS)
            ) popcount_i (
                .eval_clk  (eval_clk),
                .rstn      (rstn),
                .en        (en),
                .slice     (hard_frame[j*SUB_BITS +: SUB_BITS]),
                .sub_count (sub_counts[j*SUB_CNT_W +: SUB_CNT_W])
            );
        end else begin : g_last
            // Short sub-frame takes the top bits
            subframe_popcount #(
                .WIDTH (LAST_SUB_BITS)
            ) popcount_i (
                .eval_clk  (eval_clk),
                .rstn      (rstn),
                .en        (en),
                .slice     (hard_frame[CHUNK_BITS-1 -: LAST_SUB_BITS]),
                .sub_count (sub_counts[j*SUB_CNT_W +: SUB_CNT_W])
            );
        end
    end

    ////////////////////////////////////////////////////////////
    // Sum, normalise, accumulate
    ////////////////////////////////////////////////////////////

    count_sum_tree sum_tree_i (
        .eval_clk   (eval_clk),
        .rstn       (rstn),
        .sub_counts (sub_counts),
        .ones_sum   (ones_sum)
    );

    err_accumulator acc_i (
        .eval_clk     (eval_clk),
        .rstn         (rstn),
        .ones_sum     (ones_sum),
        .acc_valid    (acc_valid),
        .acc_first    (acc_first),
        .err_count    (err_count),
        .is_err_frame (is_err_frame)
    );

    err_cnt_ctrl ctrl_i (
        .eval_clk   (eval_clk),
        .rstn       (rstn),
        .en         (en),
        .acc_valid  (acc_valid),
        .acc_first  (acc_first),
        .busy       (busy),
        .count_done (count_done)
    );

endmodule

//--- tb/frame_table.svh
`ifndef FRAME_TABLE_SVH
`define FRAME_TABLE_SVH

// One decoded frame of stimulus
typedef struct packed {
    // Zeros in each row chunk, chunk 0 first
    logic [0:ROW_CHUNK_NUM-1][CHUNK_CNT_W-1:0] zeros;
    // Force zeros onto the lowest and highest bit of every sub-frame
    logic                                      edge_bits;
    // Abort the frame with a reset after four chunks
    logic                                      mid_reset;
    // Idle cycles before the next frame
    logic [7:0]                                gap;
    // Expected frame error count
    logic [ERR_CNT_W-1:0]                      exp_err;
} frame_entry_t;

localparam int FRAME_NUM = 12;

// zeros per chunk | edge_bits | mid_reset | gap | exp_err
localparam frame_entry_t FRAME_TABLE [FRAME_NUM] = '{
    '{'{10'd0, 10'd0, 10'd0, 10'd0, 10'd0, 10'd0, 10'd0, 10'd0, 10'd0},
      1'b0, 1'b0, 8'd3, 13'd0},
    '{'{10'd1, 10'd0, 10'd5, 10'd12, 10'd0, 10'd3, 10'd100, 10'd0, 10'd7},
      1'b0, 1'b0, 8'd0, 13'd128},
    '{'{10'd14, 10'd14, 10'd20, 10'd14, 10'd30, 10'd14, 10'd14, 10'd50, 10'd14},
      1'b1, 1'b0, 8'd0, 13'd184},
    '{'{10'd850, 10'd850, 10'd850, 10'd850, 10'd850, 10'd850, 10'd850, 10'd850, 10'd850},
      1'b0, 1'b0, 8'd2, 13'd7650},
    '{'{10'd0, 10'd0, 10'd0, 10'd0, 10'd1, 10'd0, 10'd0, 10'd0, 10'd0},
      1'b0, 1'b0, 8'd0, 13'd1},
    '{'{10'd10, 10'd10, 10'd10, 10'd10, 10'd10, 10'd10, 10'd10, 10'd10, 10'd10},
      1'b0, 1'b1, 8'd2, 13'd0},
    '{'{10'd2, 10'd0, 10'd0, 10'd0, 10'd0, 10'd0, 10'd0, 10'd0, 10'd3},
      1'b0, 1'b0, 8'd1, 13'd5},
    '{'{10'd0, 10'd0, 10'd0, 10'd0, 10'd0, 10'd0, 10'd0, 10'd0, 10'd0},
      1'b0, 1'b0, 8'd0, 13'd0},
    '{'{10'd849, 10'd0, 10'd1, 10'd200, 10'd0, 10'd0, 10'd0, 10'd64, 10'd850},
      1'b0, 1'b0, 8'd4, 13'd1964},
    '{'{10'd14, 10'd14, 10'd14, 10'd14, 10'd14, 10'd14, 10'd14, 10'd14, 10'd14},
      1'b1, 1'b0, 8'd0, 13'd126},
    '{'{10'd400, 10'd400, 10'd400, 10'd400, 10'd400, 10'd400, 10'd400, 10'd400, 10'd400},
      1'b0, 1'b1, 8'd0, 13'd0},
    '{'{10'd3, 10'd3, 10'd3, 10'd3, 10'd3, 10'd3, 10'd3, 10'd3, 10'd3},
      1'b0, 1'b0, 8'd0, 13'd27}
};

`endif

//--- tb/err_bit_cnt_tb.sv
`timescale 1ns/100ps

module err_bit_cnt_tb
    import err_cnt_pkg::*;
();

    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 5;
    localparam logic [31:0] SEED         = 32'hd98e;
    // Edge after capture where busy drops and count_done rises
    localparam int          DONE_EDGE    = ROW_CHUNK_NUM + PIPE_DEPTH;
    localparam int          SETTLE       = 20;

    logic                  eval_clk;
    logic                  rstn;
    logic                  en;
    logic [CHUNK_BITS-1:0] hard_frame;
    logic [ERR_CNT_W-1:0]  err_count;
    logic                  is_err_frame;
    logic                  busy;
    logic                  count_done;

    int cycle_cnt   = 0;
    int checks      = 0;
    int value_errs  = 0;
    int other_errs  = 0;

    `include "frame_table.svh"

    localparam int CYCLE_LIMIT = FRAME_NUM * 40 + 200;

    err_bit_cnt_top dut_i (
        .eval_clk     (eval_clk),
        .rstn         (rstn),
        .en           (en),
        .hard_frame   (hard_frame),
        .err_count    (err_count),
        .is_err_frame (is_err_frame),
        .busy         (busy),
        .count_done   (count_done)
    );

    ////////////////////////////////////////////////////////////
    // Clock, cycle counter, watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        eval_clk = 1'b0;
        forever #(CLK_PERIOD / 2) eval_clk = ~eval_clk;
    end

    always @(posedge eval_clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(negedge eval_clk);
        end
        report_failure("Timeout, the frame table did not finish within the cycle limit");
        end_run();
    end

    ////////////////////////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////////////////////////

    task report_mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
        value_errs++;
        $display("ERR t=%0t %s expected %0d actual %0d", $time, name, exp, act);
    endtask

    task report_failure(input string what);
        other_errs++;
        $display("t=%0t %s", $time, what);
    endtask

    task end_run();
        $display("Checks %0d, value errors %0d, other errors %0d",
                 checks, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    // Start from all ones and clear bits until the zero count is reached
    function automatic logic [CHUNK_BITS-1:0] build_chunk(input int zeros,
                                                          input logic edge_bits);
        logic [CHUNK_BITS-1:0] c;
        int cleared;
        int pos;
        c = '1;
        cleared = 0;
        if (edge_bits) begin
            for (int j = 0; j < SUB_NUM - 1; j++) begin
                c[j * SUB_BITS] = 1'b0;
                c[j * SUB_BITS + SUB_BITS - 1] = 1'b0;
            end
            // Short sub-frame at the top
            c[CHUNK_BITS - LAST_SUB_BITS] = 1'b0;
            c[CHUNK_BITS - 1] = 1'b0;
            cleared = 2 * SUB_NUM;
        end
        while (cleared < zeros) begin
            pos = $urandom % CHUNK_BITS;
            if (c[pos]) begin
                c[pos] = 1'b0;
                cleared++;
            end
        end
        return c;
    endfunction

    task check_outputs_clear();
        checks++;
        assert (err_count === '0) else report_mismatch("err_count", 0, err_count);
        assert (is_err_frame === 1'b0) else report_mismatch("is_err_frame", 0, is_err_frame);
        assert (busy === 1'b0) else report_mismatch("busy", 0, busy);
        assert (count_done === 1'b0) else report_mismatch("count_done", 0, count_done);
    endtask

    // Called at the falling edge after capture edge plus m
    task check_busy(input int m);
        logic exp;
        exp = (m >= 1 && m < DONE_EDGE);
        checks++;
        assert (busy === exp) else report_mismatch("busy", exp, busy);
    endtask

    task check_result(input frame_entry_t ent);
        checks++;
        assert (err_count === ent.exp_err)
            else report_mismatch("err_count", ent.exp_err, err_count);
        assert (is_err_frame === (ent.exp_err != 0))
            else report_mismatch("is_err_frame", ent.exp_err != 0, is_err_frame);
    endtask

    ////////////////////////////////////////////////////////////
    // Frame runners start and end on a falling edge
    ////////////////////////////////////////////////////////////

    task automatic run_frame(input int e);
        frame_entry_t          ent;
        logic [CHUNK_BITS-1:0] chunks [ROW_CHUNK_NUM];
        int                    k_edge;
        ent = FRAME_TABLE[e];
        for (int i = 0; i < ROW_CHUNK_NUM; i++) begin
            chunks[i] = build_chunk(ent.zeros[i], ent.edge_bits);
        end
        checks++;
        assert (busy === 1'b0 && count_done === 1'b0)
            else report_failure("DUT not idle at the start of a frame");
        k_edge = cycle_cnt + 1;
        en = 1'b1;
        hard_frame = chunks[0];
        for (int i = 1; i < ROW_CHUNK_NUM; i++) begin
            @(negedge eval_clk);
            check_busy(cycle_cnt - k_edge);
            hard_frame = chunks[i];
        end
        @(negedge eval_clk);
        check_busy(cycle_cnt - k_edge);
        en = 1'b0;
        hard_frame = '0;
        // Wait for the result
        do begin
            @(negedge eval_clk);
            check_busy(cycle_cnt - k_edge);
        end while (!count_done);
        checks++;
        assert (cycle_cnt - k_edge == DONE_EDGE)
            else report_failure($sformatf("count_done rose %0d edges after capture, not %0d",
                                          cycle_cnt - k_edge, DONE_EDGE));
        check_result(ent);
        @(negedge eval_clk);
        check_busy(cycle_cnt - k_edge);
        checks++;
        assert (count_done === 1'b1) else report_mismatch("count_done", 1, count_done);
        check_result(ent);
        @(negedge eval_clk);
        checks++;
        assert (count_done === 1'b0) else report_mismatch("count_done", 0, count_done);
    endtask

    task automatic run_reset_frame(input int e);
        frame_entry_t ent;
        ent = FRAME_TABLE[e];
        en = 1'b1;
        hard_frame = build_chunk(ent.zeros[0], ent.edge_bits);
        for (int i = 1; i < 4; i++) begin
            @(negedge eval_clk);
            hard_frame = build_chunk(ent.zeros[i], ent.edge_bits);
        end
        @(negedge eval_clk);
        rstn = 1'b0;
        en = 1'b0;
        hard_frame = '0;
        @(negedge eval_clk);
        check_outputs_clear();
        @(negedge eval_clk);
        rstn = 1'b1;
        // Aborted frame must never report
        repeat (SETTLE) begin
            @(negedge eval_clk);
            check_outputs_clear();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(SEED));
        rstn = 1'b0;
        en = 1'b0;
        hard_frame = '0;
        repeat (RESET_CYCLES) @(negedge eval_clk);
        check_outputs_clear();
        rstn = 1'b1;
        @(negedge eval_clk);
        check_outputs_clear();
        for (int e = 0; e < FRAME_NUM; e++) begin
            if (FRAME_TABLE[e].mid_reset) begin
                run_reset_frame(e);
            end else begin
                run_frame(e);
            end
            repeat (FRAME_TABLE[e].gap) @(negedge eval_clk);
        end
        end_run();
    end

endmodule

//--- err_bit_cnt_top.f
+incdir+tb
verilog/err_cnt_pkg.sv
verilog/subframe_popcount.sv
verilog/count_sum_tree.sv
verilog/err_accumulator.sv
verilog/err_cnt_ctrl.sv
verilog/err_bit_cnt_top.sv
tb/err_bit_cnt_tb.sv
